// File: source/video_consts.svh
// Video subsystem constants
// Frame geometry, memory sizes and the CPU register map
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Horizontal geometry in pixel clocks
`define VID_HTOTAL        384
`define VID_HACTIVE       256
`define VID_HS_START      300
`define VID_HS_LEN        32

// Vertical geometry in lines
`define VID_VTOTAL        264
`define VID_VACTIVE       224
`define VID_VS_START      240
`define VID_VS_LEN        8

// Pixel clocks from the counters to the RGB outputs
`define VID_PXL_DELAY     4

// Memory sizes in bytes
`define VID_MAP_WORDS     1024
`define VID_PAL_BYTES     128

// Registers behind the gfx chip select
`define VID_CTRL_ADDR     11'h400
`define VID_IRQ_ACK_ADDR  11'h401

`endif

// File: source/video_pkg.sv
// Video subsystem types
// Counters, pixel indices, colours, bus words and the fetch states
`default_nettype none

package video_pkg;

    // Screen position counters
    typedef logic [8:0]  hcnt_t;
    typedef logic [8:0]  vcnt_t;

    // Colour bank in bits 5..2, tile pixel in bits 1..0
    typedef logic [5:0]  pxl_idx_t;
    typedef logic [4:0]  colour_t;

    // CPU bus
    typedef logic [10:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // Graphics ROM, one word per tile row
    typedef logic [17:0] rom_addr_t;
    typedef logic [15:0] rom_data_t;

    typedef enum logic [1:0] {
        IDLE,
        MAP_READ,
        ROM_REQ,
        ROM_WAIT
    } fetch_state_t;

endpackage

`default_nettype wire

// File: source/pixel_cen.sv
// Pixel clock enables
// Divides the 48 MHz system clock into 12 MHz and 6 MHz enables
`timescale 1ns/1ns
`default_nettype none

module pixel_cen (
    input  wire  clk,
    output logic cen12,
    output logic cen6
);

    // Free-running divider, any start phase works
    logic [2:0] cnt = 3'd0;

    always_ff @(posedge clk) begin
        cnt   <= cnt + 3'd1;
        // Both enables fire together once every 8 clocks
        cen12 <= cnt[1:0] == 2'b11;
        cen6  <= cnt == 3'b111;
    end

endmodule

`default_nettype wire

// File: source/video_timing.sv
// Video timing generator
// Pixel and line counters, blanking, sync and the vertical blank interrupt
`timescale 1ns/1ns
`default_nettype none
`include "video_consts.svh"

module video_timing (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       pxl_cen,
    input  wire                       cpu_cen,
    input  wire                       gfx_cs,
    input  wire                       cpu_rnw,
    input  wire video_pkg::cpu_addr_t cpu_addr,
    input  wire video_pkg::cpu_data_t cpu_dout,
    output video_pkg::hcnt_t          hdump,
    output video_pkg::vcnt_t          vdump,
    output logic                      LHBL,
    output logic                      LVBL,
    output logic                      HS,
    output logic                      VS,
    output logic                      cpu_irqn
);

    localparam video_pkg::hcnt_t H_LAST   = video_pkg::hcnt_t'(`VID_HTOTAL - 1);
    localparam video_pkg::hcnt_t H_ACTIVE = video_pkg::hcnt_t'(`VID_HACTIVE);
    localparam video_pkg::hcnt_t HS_BEGIN = video_pkg::hcnt_t'(`VID_HS_START);
    localparam video_pkg::hcnt_t HS_END   = video_pkg::hcnt_t'(`VID_HS_START + `VID_HS_LEN);
    localparam video_pkg::vcnt_t V_LAST   = video_pkg::vcnt_t'(`VID_VTOTAL - 1);
    localparam video_pkg::vcnt_t V_ACTIVE = video_pkg::vcnt_t'(`VID_VACTIVE);
    localparam video_pkg::vcnt_t VS_BEGIN = video_pkg::vcnt_t'(`VID_VS_START);
    localparam video_pkg::vcnt_t VS_END   = video_pkg::vcnt_t'(`VID_VS_START + `VID_VS_LEN);

    video_pkg::hcnt_t hnext;
    video_pkg::vcnt_t vnext;
    logic             irq_en;
    logic             cpu_wr;
    logic             vb_start;

    always_comb begin
        hnext = (hdump == H_LAST) ? '0 : hdump + 9'd1;
        vnext = vdump;
        if (hdump == H_LAST) begin
            vnext = (vdump == V_LAST) ? '0 : vdump + 9'd1;
        end
    end

    assign cpu_wr   = gfx_cs && !cpu_rnw && cpu_cen;
    // Last pixel of the last active line
    assign vb_start = pxl_cen && hdump == H_LAST && vdump == V_ACTIVE - 9'd1;

    // Flags are decoded from the next count so they line up with hdump/vdump
    always_ff @(posedge clk) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            LHBL  <= 1'b1;
            LVBL  <= 1'b1;
            HS    <= 1'b0;
            VS    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= hnext;
            vdump <= vnext;
            LHBL  <= hnext < H_ACTIVE;
            LVBL  <= vnext < V_ACTIVE;
            HS    <= hnext >= HS_BEGIN && hnext < HS_END;
            VS    <= vnext >= VS_BEGIN && vnext < VS_END;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_en   <= 1'b0;
            cpu_irqn <= 1'b1;
        end else begin
            if (cpu_wr && cpu_addr == `VID_CTRL_ADDR) begin
                irq_en <= cpu_dout[0];
            end
            if (cpu_wr && cpu_addr == `VID_IRQ_ACK_ADDR) begin
                cpu_irqn <= 1'b1;
            end
            // A new frame event takes priority over the acknowledge
            if (vb_start && irq_en) begin
                cpu_irqn <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/tile_fetch.sv
// Tile engine
// Holds the tile map, fetches one tile row per 8 pixels from the graphics
// ROM and shifts it out as 6-bit pixel indices
`timescale 1ns/1ns
`default_nettype none
`include "video_consts.svh"

module tile_fetch (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       pxl_cen,
    input  wire video_pkg::hcnt_t     hdump,
    input  wire video_pkg::vcnt_t     vdump,
    input  wire                       cpu_cen,
    input  wire                       gfx_cs,
    input  wire                       cpu_rnw,
    input  wire video_pkg::cpu_addr_t cpu_addr,
    input  wire video_pkg::cpu_data_t cpu_dout,
    output video_pkg::cpu_data_t      gfx_dout,
    output video_pkg::rom_addr_t      rom_addr,
    output logic                      rom_cs,
    input  wire video_pkg::rom_data_t rom_data,
    input  wire                       rom_ok,
    output video_pkg::pxl_idx_t       gfx_pxl
);

    // Fetch for column 0 starts one tile before the line wraps
    localparam video_pkg::hcnt_t H_WRAP_TILE = video_pkg::hcnt_t'(`VID_HTOTAL - 8);
    localparam video_pkg::hcnt_t H_LAST_GO   = video_pkg::hcnt_t'(`VID_HACTIVE - 8);
    localparam video_pkg::vcnt_t V_LAST      = video_pkg::vcnt_t'(`VID_VTOTAL - 1);

    video_pkg::cpu_data_t    map_ram [0:`VID_MAP_WORDS-1];
    video_pkg::cpu_data_t    map_q;
    video_pkg::cpu_data_t    ctrl_rb;
    video_pkg::cpu_data_t    tile_code;
    video_pkg::fetch_state_t state;
    video_pkg::vcnt_t        fetch_row;
    video_pkg::vcnt_t        next_row;
    video_pkg::rom_data_t    rom_word;
    video_pkg::rom_data_t    shift;
    logic [4:0]              fetch_col;
    logic [4:0]              next_col;
    logic [3:0]              bank;
    logic                    cpu_wr;
    logic                    tile_edge;
    logic                    boundary;
    logic                    fetch_go;
    logic                    rom_done;
    logic                    done;
    logic                    discard;
    logic                    restart;

    assign cpu_wr    = gfx_cs && !cpu_rnw && cpu_cen;
    assign tile_edge = hdump[2:0] == 3'd0;
    assign boundary  = pxl_cen && tile_edge;
    assign fetch_go  = hdump < H_LAST_GO || hdump == H_WRAP_TILE;
    assign rom_done  = state == video_pkg::ROM_WAIT && rom_ok;
    assign next_col  = (hdump == H_WRAP_TILE) ? 5'd0 : hdump[7:3] + 5'd1;
    assign next_row  = (hdump != H_WRAP_TILE) ? vdump :
                       (vdump == V_LAST) ? '0 : vdump + 9'd1;

    // CPU port and video read port of the map
    always_ff @(posedge clk) begin
        if (cpu_wr && !cpu_addr[10]) begin
            map_ram[cpu_addr[9:0]] <= cpu_dout;
        end
        if (gfx_cs) begin
            gfx_dout <= !cpu_addr[10] ? map_ram[cpu_addr[9:0]] :
                        (cpu_addr == `VID_CTRL_ADDR) ? ctrl_rb : '0;
        end
        map_q <= map_ram[{fetch_row[7:3], fetch_col}];
    end

    // Readback copy of the control register
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_rb <= '0;
        end else if (cpu_wr && cpu_addr == `VID_CTRL_ADDR) begin
            ctrl_rb <= cpu_dout;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= video_pkg::IDLE;
            rom_cs  <= 1'b0;
            done    <= 1'b0;
            discard <= 1'b0;
            restart <= 1'b0;
        end else begin
            if (rom_done) begin
                rom_cs  <= 1'b0;
                discard <= 1'b0;
                restart <= 1'b0;
                if (discard) begin
                    state <= restart ? video_pkg::MAP_READ : video_pkg::IDLE;
                end else begin
                    done  <= 1'b1;
                    state <= video_pkg::IDLE;
                end
            end else if (state == video_pkg::MAP_READ) begin
                state <= video_pkg::ROM_REQ;
            end else if (state == video_pkg::ROM_REQ) begin
                rom_cs <= 1'b1;
                state  <= video_pkg::ROM_WAIT;
            end
            // A late fetch is let run to its end and then thrown away
            if (boundary) begin
                done <= 1'b0;
                if (state == video_pkg::IDLE || rom_done) begin
                    state <= fetch_go ? video_pkg::MAP_READ : video_pkg::IDLE;
                end else begin
                    discard <= 1'b1;
                    restart <= fetch_go;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (boundary) begin
            fetch_col <= next_col;
            fetch_row <= next_row;
        end
        if (state == video_pkg::ROM_REQ) begin
            tile_code <= map_q;
            rom_addr  <= {7'd0, map_q, fetch_row[2:0]};
        end
        if (rom_done) begin
            rom_word <= rom_data;
        end
    end

    // Most significant pixel pair goes out first
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (tile_edge) begin
                shift <= done ? rom_word : '0;
                bank  <= tile_code[7:4];
            end else begin
                shift <= {shift[13:0], 2'b00};
            end
            gfx_pxl <= {bank, shift[15:14]};
        end
    end

endmodule

`default_nettype wire

// File: source/colour_mix.sv
// Colour mixer
// Palette RAM with CPU access, index to RGB lookup and blanking delay
`timescale 1ns/1ns
`default_nettype none
`include "video_consts.svh"

module colour_mix (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       pxl_cen,
    input  wire                       LHBL,
    input  wire                       LVBL,
    input  wire                       cpu_cen,
    input  wire                       pal_cs,
    input  wire                       cpu_rnw,
    input  wire video_pkg::cpu_addr_t cpu_addr,
    input  wire video_pkg::cpu_data_t cpu_dout,
    output video_pkg::cpu_data_t      pal_dout,
    input  wire video_pkg::pxl_idx_t  gfx_pxl,
    output logic                      LHBL_dly,
    output logic                      LVBL_dly,
    output video_pkg::colour_t        red,
    output video_pkg::colour_t        green,
    output video_pkg::colour_t        blue
);

    localparam int PAL_COLOURS = `VID_PAL_BYTES / 2;
    localparam int BLANK_DLY   = `VID_PXL_DELAY;

    // Even bytes hold {green[2:0], red}, odd bytes {x, blue, green[4:3]}
    video_pkg::cpu_data_t pal_lo [0:PAL_COLOURS-1];
    video_pkg::cpu_data_t pal_hi [0:PAL_COLOURS-1];
    video_pkg::cpu_data_t lo_q;
    video_pkg::cpu_data_t hi_q;
    logic [5:0]           cpu_col;
    logic [BLANK_DLY-2:0] hbl_sr;
    logic [BLANK_DLY-2:0] vbl_sr;
    logic                 pal_wr;
    logic                 vis;

    assign cpu_col = cpu_addr[6:1];
    assign pal_wr  = pal_cs && !cpu_rnw && cpu_cen;
    // Blanking as it will be seen on the delayed outputs
    assign vis     = hbl_sr[BLANK_DLY-2] && vbl_sr[BLANK_DLY-2];

    always_ff @(posedge clk) begin
        if (pal_wr && !cpu_addr[0]) begin
            pal_lo[cpu_col] <= cpu_dout;
        end
        if (pal_wr && cpu_addr[0]) begin
            pal_hi[cpu_col] <= cpu_dout;
        end
        if (pal_cs) begin
            pal_dout <= cpu_addr[0] ? pal_hi[cpu_col] : pal_lo[cpu_col];
        end
        // First pixel stage, palette lookup
        if (pxl_cen) begin
            lo_q <= pal_lo[gfx_pxl];
            hi_q <= pal_hi[gfx_pxl];
        end
    end

    // Second pixel stage, output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_sr   <= '0;
            vbl_sr   <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            hbl_sr   <= {hbl_sr[BLANK_DLY-3:0], LHBL};
            vbl_sr   <= {vbl_sr[BLANK_DLY-3:0], LVBL};
            LHBL_dly <= hbl_sr[BLANK_DLY-2];
            LVBL_dly <= vbl_sr[BLANK_DLY-2];
            if (vis) begin
                red   <= lo_q[4:0];
                green <= {hi_q[1:0], lo_q[7:5]};
                blue  <= hi_q[6:2];
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/video_top.sv
// Tile video subsystem
// Clock enables, timing generator, tile engine and colour mixer
`timescale 1ns/1ns
`default_nettype none

module video_top (
    input  wire                       clk,
    input  wire                       rst,
    output wire                       pxl2_cen,
    output wire                       pxl_cen,
    output wire                       LHBL,
    output wire                       LVBL,
    output wire                       LHBL_dly,
    output wire                       LVBL_dly,
    output wire                       HS,
    output wire                       VS,
    // CPU bus
    input  wire                       gfx_cs,
    input  wire                       pal_cs,
    input  wire                       cpu_rnw,
    input  wire                       cpu_cen,
    input  wire video_pkg::cpu_addr_t cpu_addr,
    input  wire video_pkg::cpu_data_t cpu_dout,
    output wire video_pkg::cpu_data_t gfx_dout,
    output wire video_pkg::cpu_data_t pal_dout,
    output wire                       cpu_irqn,
    // Graphics ROM
    output wire video_pkg::rom_addr_t gfx_addr,
    input  wire video_pkg::rom_data_t gfx_data,
    input  wire                       gfx_ok,
    output wire                       gfx_romcs,
    // Colours
    output wire video_pkg::colour_t   red,
    output wire video_pkg::colour_t   green,
    output wire video_pkg::colour_t   blue
);

    video_pkg::hcnt_t    hdump;
    video_pkg::vcnt_t    vdump;
    video_pkg::pxl_idx_t gfx_pxl;

    pixel_cen u_cen (
        .clk    ( clk      ),
        .cen12  ( pxl2_cen ),
        .cen6   ( pxl_cen  )
    );

    video_timing u_timing (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .cpu_cen  ( cpu_cen  ),
        .gfx_cs   ( gfx_cs   ),
        .cpu_rnw  ( cpu_rnw  ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .HS       ( HS       ),
        .VS       ( VS       ),
        .cpu_irqn ( cpu_irqn )
    );

    tile_fetch u_tiles (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .pxl_cen  ( pxl_cen   ),
        .hdump    ( hdump     ),
        .vdump    ( vdump     ),
        .cpu_cen  ( cpu_cen   ),
        .gfx_cs   ( gfx_cs    ),
        .cpu_rnw  ( cpu_rnw   ),
        .cpu_addr ( cpu_addr  ),
        .cpu_dout ( cpu_dout  ),
        .gfx_dout ( gfx_dout  ),
        .rom_addr ( gfx_addr  ),
        .rom_cs   ( gfx_romcs ),
        .rom_data ( gfx_data  ),
        .rom_ok   ( gfx_ok    ),
        .gfx_pxl  ( gfx_pxl   )
    );

    colour_mix u_colmix (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .cpu_cen  ( cpu_cen  ),
        .pal_cs   ( pal_cs   ),
        .cpu_rnw  ( cpu_rnw  ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .pal_dout ( pal_dout ),
        .gfx_pxl  ( gfx_pxl  ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

`default_nettype wire

// File: verification/video_sva.sv
// Video subsystem assertions
// Bound to video_top, covers reset state, ROM handshake, interrupt and blanking
`timescale 1ns/1ns
`default_nettype none
`include "video_consts.svh"

module video_sva (
    input wire                       clk,
    input wire                       rst,
    input wire                       gfx_cs,
    input wire                       cpu_rnw,
    input wire                       cpu_cen,
    input wire video_pkg::cpu_addr_t cpu_addr,
    input wire                       cpu_irqn,
    input wire video_pkg::rom_addr_t gfx_addr,
    input wire                       gfx_ok,
    input wire                       gfx_romcs,
    input wire                       LHBL_dly,
    input wire                       LVBL_dly,
    input wire video_pkg::colour_t   red,
    input wire video_pkg::colour_t   green,
    input wire video_pkg::colour_t   blue
);

    int   fail_count = 0;
    logic ack_wr;

    assign ack_wr = gfx_cs && !cpu_rnw && cpu_cen && cpu_addr == `VID_IRQ_ACK_ADDR;

    reset_state_a: assert property (@(posedge clk) rst |=> cpu_irqn && !gfx_romcs &&
        !LHBL_dly && !LVBL_dly && {red, green, blue} == 15'd0)
        else begin
            fail_count++;
            $error("Outputs not in their reset state");
        end

    // Address held for the whole request
    rom_addr_stable_a: assert property (@(posedge clk) disable iff (rst)
        gfx_romcs |=> !gfx_romcs || $stable(gfx_addr))
        else begin
            fail_count++;
            $error("ROM address moved while the request was open");
        end

    rom_release_a: assert property (@(posedge clk) disable iff (rst)
        gfx_romcs && gfx_ok |=> !gfx_romcs)
        else begin
            fail_count++;
            $error("ROM request still open after the acknowledge");
        end

    irq_hold_a: assert property (@(posedge clk) disable iff (rst)
        !cpu_irqn && !ack_wr |=> !cpu_irqn)
        else begin
            fail_count++;
            $error("Interrupt cleared without an acknowledge write");
        end

    irq_ack_a: assert property (@(posedge clk) disable iff (rst) ack_wr |=> cpu_irqn)
        else begin
            fail_count++;
            $error("Interrupt still pending after an acknowledge write");
        end

    blank_black_a: assert property (@(posedge clk) disable iff (rst)
        !(LHBL_dly && LVBL_dly) |-> {red, green, blue} == 15'd0)
        else begin
            fail_count++;
            $error("Colour output not black during blanking");
        end

endmodule

bind video_top video_sva sva_inst (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .gfx_cs    ( gfx_cs    ),
    .cpu_rnw   ( cpu_rnw   ),
    .cpu_cen   ( cpu_cen   ),
    .cpu_addr  ( cpu_addr  ),
    .cpu_irqn  ( cpu_irqn  ),
    .gfx_addr  ( gfx_addr  ),
    .gfx_ok    ( gfx_ok    ),
    .gfx_romcs ( gfx_romcs ),
    .LHBL_dly  ( LHBL_dly  ),
    .LVBL_dly  ( LVBL_dly  ),
    .red       ( red       ),
    .green     ( green     ),
    .blue      ( blue      )
);

`default_nettype wire

// File: verification/video_tb.sv
// Video subsystem testbench
// CPU bus and graphics ROM models, reference pixel model and test sequencing
`timescale 1ns/1ns
`default_nettype none
`include "video_consts.svh"

module video_tb;

    localparam int FRAME_CLKS = `VID_HTOTAL * `VID_VTOTAL * 8;
    // Fill, interrupt frame and measured frame all fit in three frames
    localparam int MAX_CYCLES = 3 * FRAME_CLKS;

    logic                 clk;
    logic                 rst;
    logic                 gfx_cs;
    logic                 pal_cs;
    logic                 cpu_rnw;
    logic                 cpu_cen;
    video_pkg::cpu_addr_t cpu_addr;
    video_pkg::cpu_data_t cpu_dout;
    video_pkg::rom_data_t gfx_data;
    logic                 gfx_ok;
    logic                 pxl2_cen;
    logic                 pxl_cen;
    logic                 LHBL;
    logic                 LVBL;
    logic                 LHBL_dly;
    logic                 LVBL_dly;
    logic                 HS;
    logic                 VS;
    logic                 cpu_irqn;
    logic                 gfx_romcs;
    video_pkg::cpu_data_t gfx_dout;
    video_pkg::cpu_data_t pal_dout;
    video_pkg::rom_addr_t gfx_addr;
    video_pkg::colour_t   red;
    video_pkg::colour_t   green;
    video_pkg::colour_t   blue;

    // Copies of what the CPU wrote
    video_pkg::cpu_data_t map_mem [0:`VID_MAP_WORDS-1];
    video_pkg::cpu_data_t pal_mem [0:`VID_PAL_BYTES-1];

    int seed   = 31;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests  = 0;

    video_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Graphics ROM contents
    function automatic video_pkg::rom_data_t rom_word(input video_pkg::rom_addr_t addr);
        logic [33:0] prod;
        prod = 34'(addr) * 34'h9E37;
        return prod[15:0];
    endfunction

    // ROM answers each request after 2 to 20 clocks
    initial begin
        int wait_clks;
        gfx_ok   = 1'b0;
        gfx_data = '0;
        forever begin
            @(negedge clk);
            if (gfx_romcs && !gfx_ok) begin
                wait_clks = 2 + int'($unsigned($random(seed)) % 19);
                repeat (wait_clks - 1) @(negedge clk);
                gfx_data = rom_word(gfx_addr);
                gfx_ok   = 1'b1;
                @(negedge clk);
                gfx_ok   = 1'b0;
            end
        end
    end

    task automatic expect_true(input logic ok, input string what, inout int fails);
        checks++;
        assert (ok) else begin
            errors++;
            fails++;
            $display("ERR %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name, input int fails);
        tests++;
        $display("Test %0d, %s: %0d errors", tests, name, fails);
    endtask

    task automatic cpu_write(input logic to_pal, input video_pkg::cpu_addr_t addr,
                             input video_pkg::cpu_data_t data);
        gfx_cs   = !to_pal;
        pal_cs   = to_pal;
        cpu_rnw  = 1'b0;
        cpu_cen  = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        @(negedge clk);
        gfx_cs   = 1'b0;
        pal_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b0;
    endtask

    task automatic cpu_read(input logic from_pal, input video_pkg::cpu_addr_t addr,
                            output video_pkg::cpu_data_t data);
        gfx_cs   = !from_pal;
        pal_cs   = from_pal;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b1;
        cpu_addr = addr;
        @(negedge clk);
        data     = from_pal ? pal_dout : gfx_dout;
        gfx_cs   = 1'b0;
        pal_cs   = 1'b0;
        cpu_cen  = 1'b0;
    endtask

    // Lands on the negedge inside a pixel enable where outputs are settled
    task automatic next_pixel;
        do @(negedge clk); while (!pxl_cen);
    endtask

    // Screen pixel (x, y) built from the map, ROM and palette rules
    function automatic logic [14:0] expected_rgb(input int x, input int y);
        video_pkg::cpu_data_t code;
        video_pkg::rom_data_t word;
        video_pkg::pxl_idx_t  idx;
        video_pkg::cpu_data_t lo;
        video_pkg::cpu_data_t hi;
        code = map_mem[(y / 8) * 32 + x / 8];
        word = rom_word(18'(int'(code) * 8 + y % 8));
        // Leftmost pixel in the top pair
        idx  = {code[7:4], word[15 - 2 * (x % 8) -: 2]};
        lo   = pal_mem[2 * int'(idx)];
        hi   = pal_mem[2 * int'(idx) + 1];
        return {lo[4:0], hi[1:0], lo[7:5], hi[6:2]};
    endfunction

    // Eight pixel periods sampled from a pixel enable onwards
    task automatic check_clock_enables;
        int fails;
        int k;
        fails = 0;
        next_pixel();
        for (k = 0; k < 64; k++) begin
            expect_true(pxl2_cen == (k % 4 == 0) && pxl_cen == (k % 8 == 0),
                $sformatf("clock enables wrong %0d clocks after a pixel enable", k), fails);
            @(negedge clk);
        end
        report_test("clock enables", fails);
    endtask

    task automatic check_irq_enabled;
        int                   fails;
        video_pkg::cpu_data_t rd;
        fails = 0;
        cpu_write(1'b0, `VID_CTRL_ADDR, 8'h01);
        cpu_read(1'b0, `VID_CTRL_ADDR, rd);
        expect_true(rd == 8'h01,
            $sformatf("control register read %h, expected 01", rd), fails);
        while (!LVBL) @(negedge clk);
        while (LVBL) @(negedge clk);
        expect_true(!cpu_irqn, "cpu_irqn did not fall with LVBL", fails);
        repeat (16) next_pixel();
        expect_true(!cpu_irqn, "cpu_irqn rose before the acknowledge", fails);
        cpu_write(1'b0, `VID_IRQ_ACK_ADDR, 8'h00);
        expect_true(cpu_irqn, "cpu_irqn still low after the acknowledge", fails);
        cpu_write(1'b0, `VID_CTRL_ADDR, 8'h00);
        report_test("interrupt enabled", fails);
    endtask

    task automatic check_irq_quiet;
        int   fails;
        logic fell;
        fails = 0;
        fell  = 1'b0;
        while (!LVBL) begin
            fell |= !cpu_irqn;
            @(negedge clk);
        end
        while (LVBL) begin
            fell |= !cpu_irqn;
            @(negedge clk);
        end
        repeat (64) begin
            fell |= !cpu_irqn;
            @(negedge clk);
        end
        expect_true(!fell, "cpu_irqn fell while the interrupt was disabled", fails);
        report_test("interrupt disabled", fails);
    endtask

    task automatic check_frame_timing;
        int fails;
        int ln;
        int px;
        int lhbl_px;
        int hs_px;
        int lvbl_lines;
        int vs_lines;
        fails      = 0;
        lvbl_lines = 0;
        vs_lines   = 0;
        next_pixel();
        while (LVBL) next_pixel();
        while (!LVBL) next_pixel();
        // Now at the first pixel of line 0
        for (ln = 0; ln < `VID_VTOTAL; ln++) begin
            lhbl_px     = 0;
            hs_px       = 0;
            lvbl_lines += int'(LVBL);
            vs_lines   += int'(VS);
            for (px = 0; px < `VID_HTOTAL; px++) begin
                lhbl_px += int'(LHBL);
                hs_px   += int'(HS);
                next_pixel();
            end
            expect_true(lhbl_px == `VID_HACTIVE,
                $sformatf("line %0d has LHBL high for %0d pixels", ln, lhbl_px), fails);
            expect_true(hs_px == `VID_HS_LEN,
                $sformatf("line %0d has HS high for %0d pixels", ln, hs_px), fails);
        end
        expect_true(lvbl_lines == `VID_VACTIVE,
            $sformatf("LVBL high for %0d lines", lvbl_lines), fails);
        expect_true(vs_lines == `VID_VS_LEN,
            $sformatf("VS high for %0d lines", vs_lines), fails);
        report_test("frame timing", fails);
    endtask

    task automatic check_frame_pixels;
        int          fails;
        int          x;
        int          y;
        logic [14:0] want;
        fails = 0;
        next_pixel();
        while (LVBL_dly) next_pixel();
        while (!LVBL_dly) next_pixel();
        for (y = 0; y < `VID_VACTIVE; y++) begin
            while (!LHBL_dly) next_pixel();
            for (x = 0; x < `VID_HACTIVE; x++) begin
                want = expected_rgb(x, y);
                expect_true(LHBL_dly && LVBL_dly && {red, green, blue} == want,
                    $sformatf("pixel (%0d,%0d) rgb %h, expected %h", x, y,
                              {red, green, blue}, want), fails);
                next_pixel();
            end
        end
        report_test("pixel colours", fails);
    endtask

    initial begin
        video_pkg::cpu_data_t rd;
        int                   rnd;
        int                   i;
        int                   fails;
        rst      = 1'b1;
        gfx_cs   = 1'b0;
        pal_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        repeat (4) @(negedge clk);

        fails = 0;
        expect_true(cpu_irqn && !gfx_romcs, "cpu_irqn or gfx_romcs wrong in reset", fails);
        expect_true(!LHBL_dly && !LVBL_dly && {red, green, blue} == 15'd0,
            "delayed blanking or RGB not low in reset", fails);
        report_test("reset state", fails);
        rst = 1'b0;

        // Random map and palette kept for the pixel model
        fails = 0;
        for (i = 0; i < `VID_MAP_WORDS; i++) begin
            rnd        = $random(seed);
            map_mem[i] = rnd[7:0];
            cpu_write(1'b0, 11'(i), map_mem[i]);
        end
        for (i = 0; i < `VID_PAL_BYTES; i++) begin
            rnd        = $random(seed);
            pal_mem[i] = rnd[7:0];
            cpu_write(1'b1, 11'(i), pal_mem[i]);
        end
        for (i = 0; i < `VID_MAP_WORDS; i++) begin
            cpu_read(1'b0, 11'(i), rd);
            expect_true(rd == map_mem[i],
                $sformatf("map byte %0d read %h, expected %h", i, rd, map_mem[i]), fails);
        end
        for (i = 0; i < `VID_PAL_BYTES; i++) begin
            cpu_read(1'b1, 11'(i), rd);
            expect_true(rd == pal_mem[i],
                $sformatf("palette byte %0d read %h, expected %h", i, rd, pal_mem[i]), fails);
        end
        report_test("cpu readback", fails);

        check_clock_enables();
        check_irq_enabled();
        // One frame serves the timing, pixel and quiet interrupt tests
        fork
            check_frame_timing();
            check_frame_pixels();
            check_irq_quiet();
        join

        $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests, checks, errors, uut.sva_inst.fail_count);
        if (errors == 0 && uut.sva_inst.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/video_pkg.sv
source/pixel_cen.sv
source/video_timing.sv
source/tile_fetch.sv
source/colour_mix.sv
source/video_top.sv
verification/video_sva.sv
verification/video_tb.sv

// File: Makefile
# Verilator simulation of the tile video subsystem
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= video_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
